// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_cx_core
FILELIST  = compile.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
PASS_MSG  = Verification passed

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/exec_stage.sv
design/cx_core.sv
verif/tb_cx_core.sv

// File: design/cx_core.sv
module cx_core (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           fetch_enable_i,
  input  isa_pkg::word_t                 boot_addr_i,

  // Instruction memory port
  output logic                           instr_req_o,
  output isa_pkg::word_t                 instr_addr_o,
  input  logic                           instr_gnt_i,
  input  logic                           instr_rvalid_i,
  input  isa_pkg::word_t                 instr_rdata_i,

  // Reconfigurable accelerator
  output logic                           cx_en_o,
  output isa_pkg::word_t                 cx_operand_a_o,
  output isa_pkg::word_t                 cx_operand_b_o,
  output logic [pipe_pkg::CX_FUNC_W-1:0] cx_func_o,
  input  isa_pkg::word_t                 cx_result_i,

  // Retire report
  output logic                           retire_valid_o,
  output pipe_pkg::retire_t              retire_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  // Fetch to decode
  logic      fetch_valid;
  fetch_t    fetch;
  logic      decode_ready;

  // Decode to register file
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  // Decode to execute
  logic      ex_ready;
  logic      issue_valid;
  issue_t    issue;

  ////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////

  fetch_stage u_fetch (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .fetch_valid_o  ( fetch_valid    ),
    .fetch_o        ( fetch          ),
    .decode_ready_i ( decode_ready   )
  );

  decode_stage u_decode (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .fetch_valid_i  ( fetch_valid  ),
    .fetch_i        ( fetch        ),
    .decode_ready_o ( decode_ready ),
    .rs1_addr_o     ( rs1_addr     ),
    .rs2_addr_o     ( rs2_addr     ),
    .rs1_data_i     ( rs1_data     ),
    .rs2_data_i     ( rs2_data     ),
    .ex_ready_i     ( ex_ready     ),
    .issue_valid_o  ( issue_valid  ),
    .issue_o        ( issue        )
  );

  // Written from the retire port
  reg_file u_reg_file (
    .clk_i      ( clk_i                         ),
    .rst_ni     ( rst_ni                        ),
    .rs1_addr_i ( rs1_addr                      ),
    .rs2_addr_i ( rs2_addr                      ),
    .rs1_data_o ( rs1_data                      ),
    .rs2_data_o ( rs2_data                      ),
    .we_i       ( retire_valid_o && retire_o.we ),
    .waddr_i    ( retire_o.rd                   ),
    .wdata_i    ( retire_o.result               )
  );

  exec_stage u_exec (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .issue_valid_i  ( issue_valid    ),
    .issue_i        ( issue          ),
    .ex_ready_o     ( ex_ready       ),
    .cx_en_o        ( cx_en_o        ),
    .cx_operand_a_o ( cx_operand_a_o ),
    .cx_operand_b_o ( cx_operand_b_o ),
    .cx_func_o      ( cx_func_o      ),
    .cx_result_i    ( cx_result_i    ),
    .retire_valid_o ( retire_valid_o ),
    .retire_o       ( retire_o       )
  );

endmodule

// File: design/decode_stage.sv
module decode_stage (
  input  logic               clk_i,
  input  logic               rst_ni,

  // From fetch
  input  logic               fetch_valid_i,
  input  pipe_pkg::fetch_t   fetch_i,
  output logic               decode_ready_o,

  // Register file read ports
  output isa_pkg::reg_addr_t rs1_addr_o,
  output isa_pkg::reg_addr_t rs2_addr_o,
  input  isa_pkg::word_t     rs1_data_i,
  input  isa_pkg::word_t     rs2_data_i,

  // To execute
  input  logic               ex_ready_i,
  output logic               issue_valid_o,
  output pipe_pkg::issue_t   issue_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic       dec_valid_q;
  fetch_t     dec_q;
  logic       accept;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  issue_t     issue;

  // Issue leaves on the same edge as the register file write of the
  // instruction ahead, so the write-through read covers the dependency
  assign issue_valid_o  = dec_valid_q && ex_ready_i;
  assign decode_ready_o = !dec_valid_q || ex_ready_i;
  assign accept         = fetch_valid_i && decode_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_q <= 1'b0;
    end else if (accept) begin
      dec_valid_q <= 1'b1;
    end else if (issue_valid_o) begin
      dec_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_q <= fetch_i;
    end
  end

  ////////////////////////////////////////
  // Field decode
  ////////////////////////////////////////

  assign opcode = dec_q.instr[6:0];
  assign funct3 = dec_q.instr[14:12];
  assign funct7 = dec_q.instr[31:25];
  assign imm_i  = {{20{dec_q.instr[31]}}, dec_q.instr[31:20]};

  assign rs1_addr_o = dec_q.instr[19:15];
  assign rs2_addr_o = dec_q.instr[24:20];

  always_comb begin
    issue        = '0;
    issue.pc     = dec_q.pc;
    issue.alu_op = ALU_ADD;
    issue.op_a   = rs1_data_i;
    issue.op_b   = rs2_data_i;
    issue.rd     = dec_q.instr[11:7];
    issue.func   = dec_q.instr[31:7];
    issue.delay  = funct7[CX_DELAY_W-1:0];

    unique case (opcode)
      OPC_OP: begin
        issue.we = 1'b1;
        unique case (funct3)
          F3_ADD_SUB: issue.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
          F3_XOR:     issue.alu_op = ALU_XOR;
          F3_OR:      issue.alu_op = ALU_OR;
          F3_AND:     issue.alu_op = ALU_AND;
          default:    issue.we     = 1'b0;
        endcase
        // SUB is the only funct7 variant kept
        if ((funct7 != 7'b0) && !((funct7 == F7_SUB) && (funct3 == F3_ADD_SUB))) begin
          issue.we = 1'b0;
        end
      end
      OPC_OP_IMM: begin
        // ADDI only
        issue.op_b = imm_i;
        issue.we   = (funct3 == F3_ADD_SUB);
      end
      OPC_CUSTOM0: begin
        issue.custom = 1'b1;
        issue.we     = 1'b1;
      end
      default: begin
        // Retires as a no-op
        issue.we = 1'b0;
      end
    endcase
  end

  assign issue_o = issue;

endmodule

// File: design/exec_stage.sv
module exec_stage (
  input  logic                           clk_i,
  input  logic                           rst_ni,

  // From decode
  input  logic                           issue_valid_i,
  input  pipe_pkg::issue_t               issue_i,
  output logic                           ex_ready_o,

  // Accelerator port
  output logic                           cx_en_o,
  output isa_pkg::word_t                 cx_operand_a_o,
  output isa_pkg::word_t                 cx_operand_b_o,
  output logic [pipe_pkg::CX_FUNC_W-1:0] cx_func_o,
  input  isa_pkg::word_t                 cx_result_i,

  // Retire port, also the register file write
  output logic                           retire_valid_o,
  output pipe_pkg::retire_t              retire_o
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic                  ex_valid_q;
  issue_t                ex_q;
  logic [CX_DELAY_W-1:0] cnt_q;
  logic                  done;
  word_t                 alu_result;

  // ALU ops finish in their first cycle, custom ops once the count hits the delay
  assign done       = ex_valid_q && (!ex_q.custom || (cnt_q == ex_q.delay));
  assign ex_ready_o = !ex_valid_q || done;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ex_valid_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      if (issue_valid_i) begin
        ex_valid_q <= 1'b1;
      end else if (done) begin
        ex_valid_q <= 1'b0;
      end
      if (issue_valid_i) begin
        cnt_q <= '0;
      end else if (ex_valid_q && !done) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      ex_q <= issue_i;
    end
  end

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    unique case (ex_q.alu_op)
      ALU_ADD: alu_result = ex_q.op_a + ex_q.op_b;
      ALU_SUB: alu_result = ex_q.op_a - ex_q.op_b;
      ALU_AND: alu_result = ex_q.op_a & ex_q.op_b;
      ALU_OR:  alu_result = ex_q.op_a | ex_q.op_b;
      ALU_XOR: alu_result = ex_q.op_a ^ ex_q.op_b;
      default: alu_result = '0;
    endcase
  end

  // Accelerator sees the held operands for the whole delay
  assign cx_en_o        = ex_valid_q && ex_q.custom;
  assign cx_operand_a_o = ex_q.op_a;
  assign cx_operand_b_o = ex_q.op_b;
  assign cx_func_o      = ex_q.func;

  assign retire_valid_o  = done;
  assign retire_o.pc     = ex_q.pc;
  assign retire_o.rd     = ex_q.rd;
  assign retire_o.result = ex_q.custom ? cx_result_i : alu_result;
  assign retire_o.we     = ex_q.we;

endmodule

// File: design/fetch_stage.sv
module fetch_stage (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             fetch_enable_i,
  input  isa_pkg::word_t   boot_addr_i,

  // Instruction memory port
  output logic             instr_req_o,
  output isa_pkg::word_t   instr_addr_o,
  input  logic             instr_gnt_i,
  input  logic             instr_rvalid_i,
  input  isa_pkg::word_t   instr_rdata_i,

  // To decode
  output logic             fetch_valid_o,
  output pipe_pkg::fetch_t fetch_o,
  input  logic             decode_ready_i
);
  import isa_pkg::*;
  import pipe_pkg::*;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_DATA
  } fetch_state_e;

  fetch_state_e state_q;
  fetch_state_e state_d;
  word_t        pc_q;
  logic         started_q;
  fetch_t       buf_q;
  logic         buf_valid_q;
  logic         take;
  logic         can_request;
  logic         granted;
  logic         returned;

  // Decode empties the buffer on this edge
  assign take = buf_valid_q && decode_ready_i;

  // Only request when the returned word is sure to find room
  assign can_request = fetch_enable_i && (!buf_valid_q || take);

  assign granted  = (state_q == FETCH_WAIT_GNT) && instr_gnt_i;
  assign returned = (state_q == FETCH_WAIT_DATA) && instr_rvalid_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FETCH_IDLE: begin
        if (can_request) begin
          state_d = FETCH_WAIT_GNT;
        end
      end
      FETCH_WAIT_GNT: begin
        if (instr_gnt_i) begin
          state_d = FETCH_WAIT_DATA;
        end
      end
      FETCH_WAIT_DATA: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FETCH_IDLE;
      pc_q        <= '0;
      started_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // First request of the program goes to the boot address
      if ((state_q == FETCH_IDLE) && can_request && !started_q) begin
        pc_q      <= boot_addr_i;
        started_q <= 1'b1;
      end else if (granted) begin
        pc_q <= pc_q + INSTR_STEP;
      end
      if (returned) begin
        buf_valid_q <= 1'b1;
      end else if (take) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Buffer is already empty once a request is out
  always_ff @(posedge clk_i) begin
    if (granted) begin
      buf_q.pc <= pc_q;
    end
    if (returned) begin
      buf_q.instr <= instr_rdata_i;
    end
  end

  assign instr_req_o   = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o  = pc_q;
  assign fetch_valid_o = buf_valid_q;
  assign fetch_o       = buf_q;

endmodule

// File: design/isa_pkg.sv
package isa_pkg;

  ////////////////////////////////////////
  // Data and register types
  ////////////////////////////////////////

  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // x0 included
  localparam int unsigned NUM_REGS = 32;

  // No compressed instructions, so the PC always moves by one word
  localparam word_t INSTR_STEP = 32'd4;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  // Major opcodes
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;

  // funct3 codes for the OP and OP-IMM groups
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 that turns ADD into SUB
  localparam logic [6:0] F7_SUB = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

endpackage

// File: design/pipe_pkg.sv
package pipe_pkg;

  // Accelerator function field, instruction bits 31 down to 7
  localparam int unsigned CX_FUNC_W = 25;

  // Accelerator latency, taken from the low bits of funct7
  localparam int unsigned CX_DELAY_W = 4;

  ////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////

  // Fetch to decode
  typedef struct packed {
    isa_pkg::word_t pc;
    isa_pkg::word_t instr;
  } fetch_t;

  // Decode to execute
  typedef struct packed {
    isa_pkg::word_t          pc;
    isa_pkg::alu_op_e        alu_op;
    isa_pkg::word_t          op_a;
    isa_pkg::word_t          op_b;
    isa_pkg::reg_addr_t      rd;
    logic                    we;
    logic                    custom;
    logic [CX_FUNC_W-1:0]    func;
    logic [CX_DELAY_W-1:0]   delay;
  } issue_t;

  // Execute to register file and retire port
  typedef struct packed {
    isa_pkg::word_t     pc;
    isa_pkg::reg_addr_t rd;
    isa_pkg::word_t     result;
    logic               we;
  } retire_t;

endpackage

// File: design/reg_file.sv
module reg_file (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  isa_pkg::reg_addr_t rs1_addr_i,
  input  isa_pkg::reg_addr_t rs2_addr_i,
  output isa_pkg::word_t     rs1_data_o,
  output isa_pkg::word_t     rs2_data_o,
  input  logic               we_i,
  input  isa_pkg::reg_addr_t waddr_i,
  input  isa_pkg::word_t     wdata_i
);
  import isa_pkg::*;

  // x0 has no storage
  word_t regs_q [1:NUM_REGS-1];
  logic  wr_en;

  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Write-through so a consumer issuing on the retire edge sees the result
  assign rs1_data_o = (rs1_addr_i == '0)                   ? '0      :
                      (wr_en && (waddr_i == rs1_addr_i))   ? wdata_i :
                                                             regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0)                   ? '0      :
                      (wr_en && (waddr_i == rs2_addr_i))   ? wdata_i :
                                                             regs_q[rs2_addr_i];

endmodule

// File: verif/tb_cx_core.sv
module tb_cx_core;
  timeunit 1ns;
  timeprecision 1ps;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int IDLE_CYCLES  = 10;
  localparam int MAX_PROG     = 64;
  localparam int LEN_A        = 40;
  localparam int LEN_B        = 60;
  localparam int RUN_OVERHEAD = 40;
  // 20 cycles per program instruction plus reset and idle time of each run
  localparam int WATCHDOG_CYCLES = (LEN_A + LEN_B) * 20 + 2 * RUN_OVERHEAD;

  logic                 clk_i;
  logic                 rst_ni         = 1'b0;
  logic                 fetch_enable_i = 1'b0;
  word_t                boot_addr_i    = '0;
  logic                 instr_req_o;
  word_t                instr_addr_o;
  logic                 instr_gnt_i    = 1'b0;
  logic                 instr_rvalid_i = 1'b0;
  word_t                instr_rdata_i  = '0;
  logic                 cx_en_o;
  word_t                cx_operand_a_o;
  word_t                cx_operand_b_o;
  logic [CX_FUNC_W-1:0] cx_func_o;
  word_t                cx_result_i    = '0;
  logic                 retire_valid_o;
  retire_t              retire_o;

  int    seed = 32'ha972_5337;
  word_t prog [0:MAX_PROG-1];
  int    prog_len = 0;
  word_t run_boot = '0;
  word_t shadow [0:NUM_REGS-1];
  int    retired = 0;
  int    tests   = 0;
  int    checks  = 0;
  int    errors  = 0;

  cx_core DUT (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .cx_en_o        ( cx_en_o        ),
    .cx_operand_a_o ( cx_operand_a_o ),
    .cx_operand_b_o ( cx_operand_b_o ),
    .cx_func_o      ( cx_func_o      ),
    .cx_result_i    ( cx_result_i    ),
    .retire_valid_o ( retire_valid_o ),
    .retire_o       ( retire_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_func(input string name, input logic [CX_FUNC_W-1:0] exp,
                            input logic [CX_FUNC_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Program, accelerator and reference
  ////////////////////////////////////////

  // Registers limited to x0..x7 so dependencies are frequent
  function automatic word_t gen_instr();
    int         kind;
    word_t      r;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [3:0] delay;
    kind  = {$random(seed)} % 10;
    r     = $random(seed);
    rd    = {2'b00, r[2:0]};
    rs1   = {2'b00, r[5:3]};
    rs2   = {2'b00, r[8:6]};
    // At least one cycle so the model can answer from sampled operands
    delay = (r[26:24] == 3'd0) ? 4'd1 : {1'b0, r[26:24]};
    case (kind)
      0:       return {7'b0000000, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
      1:       return {F7_SUB, rs2, rs1, F3_ADD_SUB, rd, OPC_OP};
      2:       return {7'b0000000, rs2, rs1, F3_AND, rd, OPC_OP};
      3:       return {7'b0000000, rs2, rs1, F3_OR, rd, OPC_OP};
      4:       return {7'b0000000, rs2, rs1, F3_XOR, rd, OPC_OP};
      5, 6, 7: return {r[20:9], rs1, F3_ADD_SUB, rd, OPC_OP_IMM};
      8:       return {r[23:21], delay, rs2, rs1, r[29:27], rd, OPC_CUSTOM0};
      default: return {r[31:7], 7'b0000011};  // Load opcode outside the subset
    endcase
  endfunction

  // Unsupported words past the program that still vary with the address
  function automatic word_t mem_word(input word_t addr);
    word_t idx;
    idx = (addr - run_boot) >> 2;
    if ((addr >= run_boot) && (idx < prog_len)) begin
      return prog[idx[5:0]];
    end
    return {addr[26:2] ^ addr[31:7], 7'b1111111};
  endfunction

  function automatic word_t accel_func(input word_t a, input word_t b,
                                       input logic [CX_FUNC_W-1:0] func);
    return (a + b) ^ {{(XLEN - CX_FUNC_W){1'b0}}, func};
  endfunction

  function automatic retire_t ref_retire(input word_t instr, input word_t pc);
    retire_t    exp;
    word_t      a;
    word_t      b;
    word_t      imm;
    logic [6:0] f7;
    logic [2:0] f3;
    a          = shadow[instr[19:15]];
    b          = shadow[instr[24:20]];
    imm        = {{20{instr[31]}}, instr[31:20]};
    f7         = instr[31:25];
    f3         = instr[14:12];
    exp.pc     = pc;
    exp.rd     = instr[11:7];
    exp.we     = 1'b0;
    exp.result = '0;
    case (instr[6:0])
      OPC_OP: begin
        if (f7 == 7'b0000000) begin
          exp.we = 1'b1;
          case (f3)
            F3_ADD_SUB: exp.result = a + b;
            F3_XOR:     exp.result = a ^ b;
            F3_OR:      exp.result = a | b;
            F3_AND:     exp.result = a & b;
            default:    exp.we     = 1'b0;
          endcase
        end else if ((f7 == F7_SUB) && (f3 == F3_ADD_SUB)) begin
          exp.we     = 1'b1;
          exp.result = a - b;
        end
      end
      OPC_OP_IMM: begin
        if (f3 == F3_ADD_SUB) begin
          exp.we     = 1'b1;
          exp.result = a + imm;
        end
      end
      OPC_CUSTOM0: begin
        exp.we     = 1'b1;
        exp.result = accel_func(a, b, instr[31:7]);
      end
      default: begin
      end
    endcase
    return exp;
  endfunction

  ////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////

  always @(posedge clk_i) begin : memory_model
    static int    gnt_wait   = -1;
    static int    data_wait  = -1;
    static word_t data_addr  = '0;
    static word_t next_fetch = '0;
    if (!rst_ni) begin
      instr_gnt_i    <= 1'b0;
      instr_rvalid_i <= 1'b0;
      gnt_wait       = -1;
      data_wait      = -1;
      next_fetch     = run_boot;
    end else begin
      instr_rvalid_i <= 1'b0;
      // Grant was seen by the DUT on this edge
      if (instr_gnt_i) begin
        instr_gnt_i <= 1'b0;
        check_word("instr_addr_o", next_fetch, instr_addr_o);
        next_fetch = next_fetch + 32'd4;
        data_addr  = instr_addr_o;
        data_wait  = {$random(seed)} % 3;
      end else if (instr_req_o) begin
        if (gnt_wait < 0) begin
          gnt_wait = {$random(seed)} % 3;
        end
        if (gnt_wait == 0) begin
          instr_gnt_i <= 1'b1;
        end
        gnt_wait = gnt_wait - 1;
      end
      if (data_wait == 0) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= mem_word(data_addr);
        data_wait      = -1;
      end else if (data_wait > 0) begin
        data_wait = data_wait - 1;
      end
    end
  end

  ////////////////////////////////////////
  // Accelerator model and retire checker
  ////////////////////////////////////////

  always @(posedge clk_i) begin : retire_checker
    retire_t exp;
    word_t   instr;
    if (!rst_ni) begin
      retired     = 0;
      shadow      = '{default: '0};
      cx_result_i <= '0;
    end else begin
      cx_result_i <= '0;
      if (cx_en_o) begin
        cx_result_i <= accel_func(cx_operand_a_o, cx_operand_b_o, cx_func_o);
        if (retired < prog_len) begin
          instr = prog[retired[5:0]];
          if (instr[6:0] != OPC_CUSTOM0) begin
            errors++;
            $display("At %0t ns cx_en_o is high while a non-custom instruction executes",
                     $time);
          end
          check_word("cx_operand_a_o", shadow[instr[19:15]], cx_operand_a_o);
          check_word("cx_operand_b_o", shadow[instr[24:20]], cx_operand_b_o);
          check_func("cx_func_o", instr[31:7], cx_func_o);
        end
      end
      if (retire_valid_o && (retired < prog_len)) begin
        exp = ref_retire(prog[retired[5:0]], run_boot + 32'd4 * word_t'(retired));
        check_word("retire_o.pc", exp.pc, retire_o.pc);
        check_reg("retire_o.rd", exp.rd, retire_o.rd);
        check_flag("retire_o.we", exp.we, retire_o.we);
        if (exp.we) begin
          check_word("retire_o.result", exp.result, retire_o.result);
        end
        // x0 is never written in the shadow copy
        if (exp.we && (exp.rd != '0)) begin
          shadow[exp.rd] = exp.result;
        end
        retired++;
      end
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  task automatic run_program(input word_t boot, input int len);
    int err_start;
    int i;
    err_start = errors;
    rst_ni         <= 1'b0;
    fetch_enable_i <= 1'b0;
    boot_addr_i    <= boot;
    @(posedge clk_i);
    run_boot = boot;
    prog_len = len;
    for (i = 0; i < len; i++) begin
      prog[i[5:0]] = gen_instr();
    end
    repeat (RESET_CYCLES - 1) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Fetch stays quiet until enabled
    repeat (IDLE_CYCLES) begin
      @(posedge clk_i);
      check_flag("instr_req_o", 1'b0, instr_req_o);
      check_flag("cx_en_o", 1'b0, cx_en_o);
      check_flag("retire_valid_o", 1'b0, retire_valid_o);
    end
    tests++;
    $display("Test %0d: idle after reset, boot %h, %0d errors",
             tests, boot, errors - err_start);

    err_start = errors;
    fetch_enable_i <= 1'b1;
    wait (retired == len);
    tests++;
    $display("Test %0d: %0d instructions retired from %h, %0d errors",
             tests, len, boot, errors - err_start);
  endtask

  initial begin
    run_program(32'h0000_1000, LEN_A);
    run_program(32'h8000_0400, LEN_B);
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Retirement stalled with %0d of %0d instructions retired", retired, prog_len);
    $display("Verification failed");
    $finish;
  end

endmodule
